// ==== common/dump_config.svh ====
`ifndef DUMP_CONFIG_SVH
`define DUMP_CONFIG_SVH

// words read per dump
`define DUMP_WORDS 4

// clk cycles per SPI clock half period
`define SPI_HALF_DIV 2

// clk cycles per UART bit
`define UART_CLKS_PER_BIT 16

// standard slow read opcode
`define FLASH_READ_CMD 8'h03

`endif

// ==== common/dump_pkg.sv ====
package dump_pkg;

   // read request, one per flash word
   typedef struct packed {
      logic        last;  // final word of the dump
      logic [23:0] addr;  // byte address in flash
   } rd_req_t;

   // word returned by the SPI reader
   typedef struct packed {
      logic        last;
      logic [31:0] data;  // first byte read sits in 7:0
   } rd_word_t;

   // byte handed to the UART
   typedef struct packed {
      logic       last;  // last byte of the dump
      logic [7:0] data;
   } tx_byte_t;

   typedef enum logic [1:0] {
      CTRL_IDLE,
      CTRL_ISSUE,
      CTRL_WAIT_END
   } ctrl_state_e;

   typedef enum logic [2:0] {
      SPI_IDLE,
      SPI_CMD,
      SPI_ADDR,
      SPI_DATA,
      SPI_DONE
   } spi_state_e;

   typedef enum logic [1:0] {
      UART_IDLE,
      UART_START,
      UART_DATA,
      UART_STOP
   } uart_state_e;

endpackage

// ==== hdl/dump_ctrl.sv ====
`timescale 1ns/1ps
`include "dump_config.svh"

module dump_ctrl import dump_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic        start,
   input  logic [23:0] start_addr,
   output logic        req_valid,
   output rd_req_t     req,
   input  logic        req_ready,
   input  logic        frame_last_end,
   output logic        busy
);

   localparam int CNT_W = $clog2(`DUMP_WORDS + 1);

   ctrl_state_e      state;
   logic [23:0]      addr;
   logic [CNT_W-1:0] cnt;
   logic             last_word;
   logic             req_fire;

   assign last_word = (cnt == CNT_W'(`DUMP_WORDS - 1));
   assign req_fire  = req_valid && req_ready;

   assign req.addr = addr;
   assign req.last = last_word;

   // drops together with the done pulse
   assign busy = (state != CTRL_IDLE) && !frame_last_end;

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= CTRL_IDLE;
         req_valid <= 1'b0;
         cnt       <= '0;
      end else begin
         case (state)
            CTRL_IDLE: begin
               if (start) begin
                  state     <= CTRL_ISSUE;
                  req_valid <= 1'b1;
                  cnt       <= '0;
               end
            end
            CTRL_ISSUE: begin
               if (req_fire) begin
                  if (last_word) begin
                     state     <= CTRL_WAIT_END;
                     req_valid <= 1'b0;
                  end else begin
                     cnt <= cnt + 1'b1;  // next word, valid stays up
                  end
               end
            end
            CTRL_WAIT_END: begin
               if (frame_last_end) begin
                  state <= CTRL_IDLE;
               end
            end
            default: state <= CTRL_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == CTRL_IDLE && start) begin
         addr <= start_addr;
      end else if (req_fire) begin
         addr <= addr + 24'd4;  // one word per request
      end
   end

   // a pending request must not change under the reader
   req_hold_a: assert property (@(posedge clk) disable iff (rst)
      req_valid && !req_ready |=> req_valid && $stable(req));

   // the last frame can only finish once every request is out
   last_end_a: assert property (@(posedge clk) disable iff (rst)
      frame_last_end |-> state == CTRL_WAIT_END);

endmodule

// ==== spi/spi_flash_reader.sv ====
`timescale 1ns/1ps
`include "dump_config.svh"

module spi_flash_reader import dump_pkg::*; (
   input  logic     clk,
   input  logic     rst,
   input  logic     req_valid,
   input  rd_req_t  req,
   output logic     req_ready,
   output logic     word_valid,
   output rd_word_t word,
   input  logic     word_ready,
   output logic     spi_sck,
   output logic     spi_cs_n,
   output logic     spi_mosi,
   input  logic     spi_miso
);

   localparam int DIV_W = $clog2(`SPI_HALF_DIV + 1);

   spi_state_e       state;
   logic [DIV_W-1:0] div;
   logic             half_end;
   logic             shifting;
   logic [4:0]       bit_cnt;
   logic [31:0]      tx_sr;
   logic [31:0]      rx_sr;
   logic             last_q;
   logic             sck_q;
   logic             cs_n_q;
   logic             valid_q;

   assign shifting  = (state == SPI_CMD) || (state == SPI_ADDR) || (state == SPI_DATA);
   assign half_end  = shifting && (div == DIV_W'(`SPI_HALF_DIV - 1));
   assign req_ready = (state == SPI_IDLE);

   assign spi_sck  = sck_q;
   assign spi_cs_n = cs_n_q;
   assign spi_mosi = tx_sr[31] && !cs_n_q;

   // bytes arrive msb first, first one goes to the low byte
   assign word_valid = valid_q;
   assign word.data  = {rx_sr[7:0], rx_sr[15:8], rx_sr[23:16], rx_sr[31:24]};
   assign word.last  = last_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= SPI_IDLE;
         div     <= '0;
         bit_cnt <= '0;
         sck_q   <= 1'b0;
         cs_n_q  <= 1'b1;
         valid_q <= 1'b0;
      end else begin
         if (shifting) begin
            div <= half_end ? '0 : div + 1'b1;
         end
         case (state)
            SPI_IDLE: begin
               if (req_valid) begin
                  state   <= SPI_CMD;
                  cs_n_q  <= 1'b0;
                  div     <= '0;
                  bit_cnt <= '0;
               end
            end
            SPI_CMD, SPI_ADDR, SPI_DATA: begin
               if (half_end) begin
                  sck_q <= !sck_q;
                  if (sck_q) begin  // falling edge ends a bit
                     bit_cnt <= bit_cnt + 1'b1;
                     if (state == SPI_CMD && bit_cnt == 5'd7) begin
                        state <= SPI_ADDR;
                     end else if (state == SPI_ADDR && bit_cnt == 5'd31) begin
                        state <= SPI_DATA;  // counter wraps to 0
                     end else if (state == SPI_DATA && bit_cnt == 5'd31) begin
                        state  <= SPI_DONE;
                        cs_n_q <= 1'b1;
                     end
                  end
               end
            end
            SPI_DONE: begin
               if (!valid_q) begin
                  valid_q <= 1'b1;  // one cycle after cs_n rises
               end else if (word_ready) begin
                  valid_q <= 1'b0;
                  state   <= SPI_IDLE;
               end
            end
            default: state <= SPI_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == SPI_IDLE && req_valid) begin
         tx_sr  <= {`FLASH_READ_CMD, req.addr};
         last_q <= req.last;
      end else if (half_end) begin
         if (sck_q) begin
            tx_sr <= {tx_sr[30:0], 1'b0};  // mosi moves on falling sck
         end else if (state == SPI_DATA) begin
            rx_sr <= {rx_sr[30:0], spi_miso};  // sample on rising sck
         end
      end
   end

   // mode 0 clock idles low outside a transaction
   sck_idle_a: assert property (@(posedge clk) disable iff (rst)
      spi_cs_n |-> !spi_sck);

endmodule

// ==== hdl/word_unpacker.sv ====
`timescale 1ns/1ps

module word_unpacker import dump_pkg::*; (
   input  logic     clk,
   input  logic     rst,
   input  logic     word_valid,
   input  rd_word_t word,
   output logic     word_ready,
   output logic     byte_valid,
   output tx_byte_t tx_data,
   input  logic     byte_ready
);

   rd_word_t   word_q;
   logic       full;
   logic [1:0] idx;
   logic       byte_fire;

   assign word_ready = !full;
   assign byte_valid = full;
   assign byte_fire  = byte_valid && byte_ready;

   assign tx_data.data = word_q.data[idx*8 +: 8];
   assign tx_data.last = word_q.last && (idx == 2'd3);  // only the final byte of the dump

   always_ff @(posedge clk) begin
      if (rst) begin
         full <= 1'b0;
         idx  <= '0;
      end else if (!full) begin
         if (word_valid) begin
            full <= 1'b1;
            idx  <= '0;
         end
      end else if (byte_fire) begin
         idx <= idx + 1'b1;
         if (idx == 2'd3) begin
            full <= 1'b0;  // free for the next word
         end
      end
   end

   always_ff @(posedge clk) begin
      if (word_valid && word_ready) begin
         word_q <= word;
      end
   end

endmodule

// ==== uart/uart_tx.sv ====
`timescale 1ns/1ps
`include "dump_config.svh"

module uart_tx import dump_pkg::*; (
   input  logic     clk,
   input  logic     rst,
   input  logic     byte_valid,
   input  tx_byte_t tx_data,
   output logic     byte_ready,
   output logic     uart_tx_pin,
   output logic     frame_last_end
);

   localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT + 1);

   uart_state_e      state;
   logic [CNT_W-1:0] cnt;
   logic             bit_end;
   logic [2:0]       bit_idx;
   logic [7:0]       sh;
   logic             last_q;

   assign bit_end    = (cnt == CNT_W'(`UART_CLKS_PER_BIT - 1));
   assign byte_ready = (state == UART_IDLE);

   always_ff @(posedge clk) begin
      if (rst) begin
         state          <= UART_IDLE;
         cnt            <= '0;
         bit_idx        <= '0;
         uart_tx_pin    <= 1'b1;
         frame_last_end <= 1'b0;
      end else begin
         frame_last_end <= 1'b0;
         if (state != UART_IDLE) begin
            cnt <= bit_end ? '0 : cnt + 1'b1;
         end
         case (state)
            UART_IDLE: begin
               if (byte_valid) begin
                  state       <= UART_START;
                  cnt         <= '0;
                  uart_tx_pin <= 1'b0;  // start bit
               end
            end
            UART_START: begin
               if (bit_end) begin
                  state       <= UART_DATA;
                  bit_idx     <= '0;
                  uart_tx_pin <= sh[0];
               end
            end
            UART_DATA: begin
               if (bit_end) begin
                  if (bit_idx == 3'd7) begin
                     state       <= UART_STOP;
                     uart_tx_pin <= 1'b1;
                  end else begin
                     bit_idx     <= bit_idx + 1'b1;
                     uart_tx_pin <= sh[1];  // sh shifts this same edge
                  end
               end
            end
            UART_STOP: begin
               if (bit_end) begin
                  state          <= UART_IDLE;
                  frame_last_end <= last_q;
               end
            end
            default: state <= UART_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == UART_IDLE && byte_valid) begin
         sh     <= tx_data.data;
         last_q <= tx_data.last;
      end else if (state == UART_DATA && bit_end) begin
         sh <= {1'b0, sh[7:1]};  // lsb first
      end
   end

   // line must rest at mark between frames
   idle_mark_a: assert property (@(posedge clk) disable iff (rst)
      state == UART_IDLE |-> uart_tx_pin);

endmodule

// ==== hdl/hex_dump.sv ====
`timescale 1ns/1ps

module hex_dump import dump_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic        start,
   input  logic [23:0] start_addr,
   output logic        busy,
   output logic        done,
   output logic        uart_tx_pin,
   output logic        spi_sck,
   output logic        spi_cs_n,
   output logic        spi_mosi,
   input  logic        spi_miso
);

   logic     req_valid;
   logic     req_ready;
   rd_req_t  req;
   logic     word_valid;
   logic     word_ready;
   rd_word_t word;
   logic     byte_valid;
   logic     byte_ready;
   tx_byte_t tx_data;

   dump_ctrl ctrl_i (
      .clk            (clk),
      .rst            (rst),
      .start          (start),
      .start_addr     (start_addr),
      .req_valid      (req_valid),
      .req            (req),
      .req_ready      (req_ready),
      .frame_last_end (done),
      .busy           (busy)
   );

   spi_flash_reader reader_i (
      .clk        (clk),
      .rst        (rst),
      .req_valid  (req_valid),
      .req        (req),
      .req_ready  (req_ready),
      .word_valid (word_valid),
      .word       (word),
      .word_ready (word_ready),
      .spi_sck    (spi_sck),
      .spi_cs_n   (spi_cs_n),
      .spi_mosi   (spi_mosi),
      .spi_miso   (spi_miso)
   );

   word_unpacker unpacker_i (
      .clk        (clk),
      .rst        (rst),
      .word_valid (word_valid),
      .word       (word),
      .word_ready (word_ready),
      .byte_valid (byte_valid),
      .tx_data    (tx_data),
      .byte_ready (byte_ready)
   );

   uart_tx uart_i (
      .clk            (clk),
      .rst            (rst),
      .byte_valid     (byte_valid),
      .tx_data        (tx_data),
      .byte_ready     (byte_ready),
      .uart_tx_pin    (uart_tx_pin),
      .frame_last_end (done)  // also the done output
   );

endmodule

// ==== testbench/flash_model.sv ====
`timescale 1ns/1ps
`include "dump_config.svh"

module flash_model (
   input  logic spi_sck,
   input  logic spi_cs_n,
   input  logic spi_mosi,
   output logic spi_miso
);

   logic [31:0] cmd_addr;  // opcode then 24-bit address
   logic [23:0] rd_addr;
   logic [7:0]  rd_byte;

   function automatic logic [7:0] byte_at(logic [23:0] a);
      return a[7:0] ^ a[15:8] ^ 8'hA5;
   endfunction

   initial begin
      spi_miso = 1'b0;
      cmd_addr = '0;
      rd_addr  = '0;
      rd_byte  = '0;
      forever begin
         @(negedge spi_cs_n);
         for (int i = 0; i < 32; i++) begin
            @(posedge spi_sck);
            cmd_addr = {cmd_addr[30:0], spi_mosi};  // mode 0 sample
         end
         if (cmd_addr[31:24] == `FLASH_READ_CMD) begin
            rd_addr = cmd_addr[23:0];
            // first data bit leaves on the falling edge that ends the address
            for (int i = 0; i < 32; i++) begin
               @(negedge spi_sck);
               if (i % 8 == 0) begin
                  rd_byte = byte_at(rd_addr + 24'(i / 8));
               end
               spi_miso = rd_byte[7];  // msb first
               rd_byte  = rd_byte << 1;
            end
         end
         @(posedge spi_cs_n);
      end
   end

endmodule

// ==== testbench/tb_hex_dump.sv ====
`timescale 1ns/1ps
`include "dump_config.svh"

module tb_hex_dump import dump_pkg::*; ();

   localparam int CLK_NS       = 10;
   localparam int NUM_TESTS    = 5;
   localparam int DUMP_BYTES   = 4 * `DUMP_WORDS;
   localparam int FRAME_CYCLES = 10 * `UART_CLKS_PER_BIT;
   localparam int READ_CYCLES  = 64 * 2 * `SPI_HALF_DIV + 4;  // 64 spi bits plus handshakes
   localparam int DUMP_LIMIT   = DUMP_BYTES * (FRAME_CYCLES + READ_CYCLES);
   localparam int WATCHDOG_NS  = NUM_TESTS * DUMP_LIMIT * 2 * CLK_NS;
   localparam int QUIET_CYCLES = 2 * FRAME_CYCLES + READ_CYCLES;

   logic        clk;
   logic        rst;
   logic        start;
   logic [23:0] start_addr;
   logic        busy;
   logic        done;
   logic        uart_tx_pin;
   logic        spi_sck;
   logic        spi_cs_n;
   logic        spi_mosi;
   logic        spi_miso;
   logic [7:0]  rx_q[$];  // bytes decoded from the uart line
   int          done_count = 0;
   int          bytes_at_done = 0;  // received bytes when done pulsed
   int          dumps_run;
   int          error_count;
   integer      seed;

   hex_dump dut_i (
      .clk         (clk),
      .rst         (rst),
      .start       (start),
      .start_addr  (start_addr),
      .busy        (busy),
      .done        (done),
      .uart_tx_pin (uart_tx_pin),
      .spi_sck     (spi_sck),
      .spi_cs_n    (spi_cs_n),
      .spi_mosi    (spi_mosi),
      .spi_miso    (spi_miso)
   );

   flash_model flash_i (
      .spi_sck  (spi_sck),
      .spi_cs_n (spi_cs_n),
      .spi_mosi (spi_mosi),
      .spi_miso (spi_miso)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_NS / 2) clk = ~clk;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns, the dump never completed", WATCHDOG_NS);
      stop_on_error();
   end

   always @(negedge clk) begin
      if (done === 1'b1) done_count++;
   end

   initial begin : uart_decoder
      logic [7:0] rx;
      forever begin
         @(negedge uart_tx_pin);
         repeat (`UART_CLKS_PER_BIT / 2) @(negedge clk);  // to bit center
         if (uart_tx_pin !== 1'b0) begin
            $display("start bit at %0t did not last to its center", $time);
            stop_on_error();
         end
         for (int i = 0; i < 8; i++) begin
            repeat (`UART_CLKS_PER_BIT) @(negedge clk);
            rx = {uart_tx_pin, rx[7:1]};  // lsb arrives first
         end
         repeat (`UART_CLKS_PER_BIT) @(negedge clk);
         if (uart_tx_pin !== 1'b1) begin
            $display("framing error at %0t, stop bit was low", $time);
            stop_on_error();
         end
         rx_q.push_back(rx);
      end
   end

   function automatic logic [7:0] flash_byte(logic [23:0] a);
      return a[7:0] ^ a[15:8] ^ 8'hA5;
   endfunction

   task automatic stop_on_error();
      error_count++;
      $display("Finished with errors");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_byte(string name, logic [7:0] got, logic [7:0] exp);
      if (got !== exp) begin
         $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_addr_word(string name, rd_word_t got, rd_word_t exp);
      if (got !== exp) begin
         $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_flag(string name, logic got, logic exp);
      if (got !== exp) begin
         $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_count(string name, int got, int exp);
      if (got != exp) begin
         $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
         stop_on_error();
      end
   endtask

   task automatic pulse_start(logic [23:0] addr);
      @(posedge clk);
      start      <= 1'b1;
      start_addr <= addr;
      @(posedge clk);
      start <= 1'b0;
   endtask

   task automatic start_dump(logic [23:0] addr);
      dumps_run++;
      pulse_start(addr);
   endtask

   // busy must hold until the single done cycle
   task automatic wait_dump_end();
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (done !== 1'b1) begin
         check_flag("busy", busy, 1'b1);
         cycles++;
         if (cycles > DUMP_LIMIT) begin
            $display("dump still running after %0d cycles", DUMP_LIMIT);
            stop_on_error();
         end
         @(negedge clk);
      end
      check_flag("busy at done", busy, 1'b0);
      bytes_at_done = rx_q.size();
   endtask

   task automatic check_stream(logic [23:0] base);
      rd_word_t    got;
      rd_word_t    exp;
      logic [7:0]  b;
      logic [23:0] a;
      check_count("received bytes", rx_q.size(), DUMP_BYTES);
      for (int w = 0; w < `DUMP_WORDS; w++) begin
         for (int k = 0; k < 4; k++) begin
            a = base + 24'(4 * w + k);
            b = rx_q.pop_front();
            check_byte($sformatf("byte %0d from %h", 4 * w + k, base), b, flash_byte(a));
            got.data = {b, got.data[31:8]};  // first byte ends in 7:0
            exp.data = {flash_byte(a), exp.data[31:8]};
         end
         got.last = (bytes_at_done == 4 * (w + 1));  // done right after this word
         exp.last = (w == `DUMP_WORDS - 1);
         check_addr_word($sformatf("word %0d from %h", w, base), got, exp);
      end
   endtask

   task automatic expect_quiet();
      repeat (QUIET_CYCLES) @(negedge clk);
      check_count("extra bytes", rx_q.size(), 0);
      check_flag("busy when idle", busy, 1'b0);
      check_count("done pulses", done_count, dumps_run);
   endtask

   task automatic reset_outputs();
      @(negedge clk);
      check_flag("busy", busy, 1'b0);
      check_flag("done", done, 1'b0);
      check_flag("spi_cs_n", spi_cs_n, 1'b1);
      check_flag("spi_sck", spi_sck, 1'b0);
      check_flag("uart_tx_pin", uart_tx_pin, 1'b1);
   endtask

   task automatic single_dump();
      start_dump(24'h000000);
      wait_dump_end();
      check_stream(24'h000000);
      expect_quiet();
   endtask

   task automatic busy_start_ignored();
      start_dump(24'h000000);
      repeat (READ_CYCLES + 40) @(posedge clk);  // first word is in flight
      pulse_start(24'h5A5A5A);
      wait_dump_end();
      check_stream(24'h000000);
      expect_quiet();
   endtask

   task automatic random_base_dumps();
      logic [23:0] bases[3];
      bases[0] = 24'($random(seed)) | 24'h1;  // odd, never word aligned
      bases[1] = 24'($random(seed));
      bases[2] = {8'($random(seed)), 8'($random(seed)), 8'hF6};  // runs over a page end
      foreach (bases[i]) begin
         start_dump(bases[i]);
         wait_dump_end();
         check_stream(bases[i]);
         expect_quiet();
      end
   endtask

   task automatic back_to_back_dumps();
      start_dump(24'h0001FC);
      wait_dump_end();
      check_stream(24'h0001FC);
      start_dump(24'h00ABCD);  // lands in the cycle after done
      wait_dump_end();
      check_stream(24'h00ABCD);
      expect_quiet();
   endtask

   initial begin
      seed        = 57186;
      rst         = 1'b1;
      start       = 1'b0;
      start_addr  = '0;
      dumps_run   = 0;
      error_count = 0;
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      reset_outputs();
      single_dump();
      busy_start_ignored();
      random_base_dumps();
      back_to_back_dumps();
      if (error_count == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// ==== list.f ====
+incdir+common
common/dump_pkg.sv
hdl/dump_ctrl.sv
spi/spi_flash_reader.sv
hdl/word_unpacker.sv
uart/uart_tx.sv
hdl/hex_dump.sv
testbench/flash_model.sv
testbench/tb_hex_dump.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_hex_dump
FILE_LIST := list.f
VFLAGS    := --binary --timing --assert -j 0
BUILD_DIR := obj_dir
PASS_MSG  := Finished with no errors

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILE_LIST)) common/dump_config.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM)
	@out="$$($(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
